// ==== verilog.f ====
+incdir+source
source/video_pkg.sv
source/timing_pkg.sv
source/pal_video_gen.sv
source/line_buffer.sv
source/vga_scandoubler.sv
source/tld_video.sv
testbench/tb_tld_video.sv

// ==== Makefile ====
TOP = tb_tld_video

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== testbench/tb_tld_video.sv ====
`timescale 1ns/1ps

`include "video_macros.svh"

module tb_tld_video;

   localparam int     CLK_PERIOD  = 10;
   // one input line in sysclk cycles
   localparam int     LINE_CYCLES = 2 * `H_TOTAL;
   // seven input frames
   localparam longint WATCHDOG_NS = 64'd7 * `V_TOTAL * LINE_CYCLES * CLK_PERIOD;

   // DUT inputs
   logic       sysclk;
   logic       rst_n;
   logic       vga_enable;
   logic       scanlines_enable;

   // board pins
   logic [5:0] r;
   logic [5:0] g;
   logic [5:0] b;
   logic       hsync;
   logic       vsync;

   int sync_errors    = 0;
   int pixel_errors   = 0;
   int reset_errors   = 0;
   int pixels_checked = 0;
   int reset_cycles   = 0;

   // history of the output, one sample back
   logic hs_prev   = 1'b1;
   logic vs_prev   = 1'b1;
   logic mode_prev = 1'b1;
   logic dbl_lock  = 1'b0;
   logic bp_lock   = 1'b0;
   int   x_reg        = 0;
   int   out_line_reg = 0;
   int   base_reg     = 0;
   int   low_cnt      = 0;
   int   last_low     = 0;
   int   dbl_frames   = 0;
   int   bp_frames    = 0;

   // model of the current sample
   logic       hs_fall;
   logic       hs_rise;
   logic       vs_fall;
   logic       long_pulse;
   logic       dbl_check;
   logic       bp_check;
   int         x;
   int         gap;
   int         out_line;
   int         base;
   logic [8:0] pix;
   logic [8:0] exp_dbl;
   logic [8:0] exp_bp;

   tld_video dut_i (
      .sysclk           (sysclk),
      .rst_n            (rst_n),
      .vga_enable       (vga_enable),
      .scanlines_enable (scanlines_enable),
      .r                (r),
      .g                (g),
      .b                (b),
      .hsync            (hsync),
      .vsync            (vsync)
   );

   initial begin
      sysclk = 1'b0;
      forever #(CLK_PERIOD / 2) sysclk = ~sysclk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // coordinate pattern, black outside the visible area
   // layout r, g, b from the top bit down
   function automatic logic [8:0] pattern_at(input int hc, input int vc);
      logic [8:0] p;
      p = '0;
      if (hc < `H_ACTIVE && vc < `V_ACTIVE) begin
         p[8:6] = hc[5:3];
         p[5:3] = vc[2:0];
         p[2:0] = hc[8:6];
      end
      return p;
   endfunction

   // each 3-bit channel halved
   function automatic logic [8:0] dim_channels(input logic [8:0] p);
      return {1'b0, p[8:7], 1'b0, p[5:4], 1'b0, p[2:1]};
   endfunction

   always_comb begin
      pix        = {r[2:0], g[2:0], b[2:0]};
      hs_fall    = hs_prev && !hsync;
      hs_rise    = !hs_prev && hsync;
      vs_fall    = vs_prev && !vsync;
      // an hsync fall starts position 0 of a line
      x          = hs_fall ? 0 : x_reg + 1;
      gap        = x_reg + 1;
      // csync held low across the vsync lines
      long_pulse = last_low > 2 * `H_TOTAL;
      dbl_check  = dbl_lock && vga_enable;
      bp_check   = bp_lock && !vga_enable;
      // doubled, two output lines per input line, counted from vsync
      out_line = vs_fall ? 0 : (hs_fall ? out_line_reg + 1 : out_line_reg);
      exp_dbl  = pattern_at(x, out_line / 2);
      if (out_line % 2 == 1 && scanlines_enable) begin
         exp_dbl = dim_channels(exp_dbl);
      end
      // bypass, the fall after the long pulse is line V_SYNC_LEN + 1
      if (hs_fall) begin
         base = long_pulse ? `V_SYNC_LEN + 1 : (base_reg + 1) % `V_TOTAL;
      end else begin
         base = base_reg;
      end
      exp_bp = pattern_at((x % LINE_CYCLES) / 2, (base + x / LINE_CYCLES) % `V_TOTAL);
   end

   always @(posedge sysclk) begin
      hs_prev      <= hsync;
      vs_prev      <= vsync;
      mode_prev    <= vga_enable;
      x_reg        <= x;
      out_line_reg <= out_line;
      base_reg     <= base;
      low_cnt      <= hsync ? 0 : low_cnt + 1;
      if (!rst_n) begin
         reset_cycles <= reset_cycles + 1;
      end
      if (hs_rise) begin
         last_low <= low_cnt;
      end
      if (rst_n && (dbl_check || bp_check)) begin
         pixels_checked <= pixels_checked + 1;
      end
      if (rst_n && vs_fall && vga_enable) begin
         dbl_lock   <= 1'b1;
         dbl_frames <= dbl_frames + 1;
      end
      if (rst_n && hs_fall && long_pulse && !vga_enable) begin
         bp_lock   <= 1'b1;
         bp_frames <= bp_frames + 1;
      end
      // mode switch, find the frame again
      if (vga_enable != mode_prev) begin
         dbl_lock <= 1'b0;
         bp_lock  <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////////////////////

   // 3 bits repeated into 6 at the pins
   assert property (@(posedge sysclk) disable iff (!rst_n)
      (r[5:3] == r[2:0]) && (g[5:3] == g[2:0]) && (b[5:3] == b[2:0]))
   else begin
      pixel_errors++;
      $display("Mismatch rgb halves: r %h g %h b %h", $sampled(r), $sampled(g), $sampled(b));
   end

   // reset values, after the reset has taken hold
   assert property (@(posedge sysclk)
      (!rst_n && reset_cycles >= 2) |-> (hsync && vsync && r == '0 && g == '0 && b == '0))
   else begin
      reset_errors++;
      $display("Mismatch reset outputs: expected 1 1 00 00 00, actual %h %h %h %h %h",
               $sampled(hsync), $sampled(vsync), $sampled(r), $sampled(g), $sampled(b));
   end

   assert property (@(posedge sysclk) disable iff (!rst_n)
      (dbl_check && hs_fall) |-> (gap == `H_TOTAL))
   else begin
      sync_errors++;
      $display("Mismatch hsync period: expected %h, actual %h", `H_TOTAL, $sampled(gap));
   end

   assert property (@(posedge sysclk) disable iff (!rst_n)
      (dbl_check && hs_rise) |-> (low_cnt == `VGA_HSYNC_LEN))
   else begin
      sync_errors++;
      $display("Mismatch hsync width: expected %h, actual %h", `VGA_HSYNC_LEN,
               $sampled(low_cnt));
   end

   // 624 output lines per frame
   assert property (@(posedge sysclk) disable iff (!rst_n)
      (dbl_check && vs_fall) |-> (out_line_reg + 1 == 2 * `V_TOTAL))
   else begin
      sync_errors++;
      $display("Mismatch hsync count: expected %h, actual %h", 2 * `V_TOTAL,
               $sampled(out_line_reg) + 1);
   end

   assert property (@(posedge sysclk) disable iff (!rst_n)
      dbl_check |-> (pix == exp_dbl))
   else begin
      pixel_errors++;
      $display("Mismatch pixel (doubled): expected %h, actual %h", $sampled(exp_dbl),
               $sampled(pix));
   end

   assert property (@(posedge sysclk) disable iff (!rst_n)
      bp_check |-> vsync)
   else begin
      sync_errors++;
      $display("Mismatch vsync (bypass): expected 1, actual %h", $sampled(vsync));
   end

   // one line apart, or across the long csync pulse
   assert property (@(posedge sysclk) disable iff (!rst_n)
      (bp_check && hs_fall) |->
         (gap == LINE_CYCLES || gap == (`V_SYNC_LEN + 1) * LINE_CYCLES))
   else begin
      sync_errors++;
      $display("Mismatch hsync period (bypass): expected %h, actual %h", LINE_CYCLES,
               $sampled(gap));
   end

   assert property (@(posedge sysclk) disable iff (!rst_n)
      bp_check |-> (pix == exp_bp))
   else begin
      pixel_errors++;
      $display("Mismatch pixel (bypass): expected %h, actual %h", $sampled(exp_bp),
               $sampled(pix));
   end

   ////////////////////////////////////////////////////////////////////////////
   // sequencing
   ////////////////////////////////////////////////////////////////////////////

   task automatic wait_vga_frames(input int n);
      int target;
      target = dbl_frames + n;
      while (dbl_frames < target) @(negedge sysclk);
   endtask

   task automatic wait_bypass_frames(input int n);
      int target;
      target = bp_frames + n;
      while (bp_frames < target) @(negedge sysclk);
   endtask

   task automatic print_counts();
      $display("errors: sync %0d, pixel %0d, reset %0d (pixels compared %0d)",
               sync_errors, pixel_errors, reset_errors, pixels_checked);
   endtask

   initial begin
      int total;
      rst_n            = 1'b0;
      vga_enable       = 1'b1;
      scanlines_enable = 1'b0;
      repeat (10) @(negedge sysclk);
      rst_n = 1'b1;
      // first vsync locks, then two whole frames each
      wait_vga_frames(3);
      scanlines_enable = 1'b1;
      wait_vga_frames(2);
      vga_enable       = 1'b0;
      scanlines_enable = 1'b0;
      wait_bypass_frames(3);
      total = sync_errors + pixel_errors + reset_errors;
      if (pixels_checked == 0) begin
         $display("no output pixel was compared");
         total = total + 1;
      end
      print_counts();
      if (total == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("timeout: the run did not finish within seven frames");
      print_counts();
      $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== source/tld_video.sv ====
`timescale 1ns/1ps

module tld_video (
   input  logic       sysclk,
   input  logic       rst_n,
   input  logic       vga_enable,
   input  logic       scanlines_enable,
   output logic [5:0] r,
   output logic [5:0] g,
   output logic [5:0] b,
   output logic       hsync,
   output logic       vsync
);

   // source side, 15 kHz
   logic                clk14en;
   video_pkg::pixel_t   pixel_pal;
   timing_pkg::hcount_t hcount;
   timing_pkg::vcount_t vcount;
   logic                hsync_pal;
   logic                vsync_pal;
   logic                csync_pal;

   // VGA side
   video_pkg::pixel_t   pixel_vga;
   logic                disable_scaneffect;

   ////////////////////////////////////////////////////////////////////////////
   // video source and scandoubler
   ////////////////////////////////////////////////////////////////////////////

   pal_video_gen pal_gen_i (
      .sysclk  (sysclk),
      .rst_n   (rst_n),
      .clk14en (clk14en),
      .pixel   (pixel_pal),
      .hcount  (hcount),
      .vcount  (vcount),
      .hsync_n (hsync_pal),
      .vsync_n (vsync_pal),
      .csync_n (csync_pal)
   );

   // switch is scanlines on, scandoubler wants scanlines off
   assign disable_scaneffect = ~scanlines_enable;

   vga_scandoubler vga_out_i (
      .sysclk              (sysclk),
      .rst_n               (rst_n),
      .clk14en             (clk14en),
      .enable_scandoubling (vga_enable),
      .disable_scaneffect  (disable_scaneffect),
      .pixel               (pixel_pal),
      .hcount              (hcount),
      .vcount              (vcount),
      .hsync_ext_n         (hsync_pal),
      .vsync_ext_n         (vsync_pal),
      .csync_ext_n         (csync_pal),
      .pixel_out           (pixel_vga),
      .hsync               (hsync),
      .vsync               (vsync)
   );

   // 3 to 6 bits by repeating, full scale stays full scale
   assign r = {pixel_vga.r, pixel_vga.r};
   assign g = {pixel_vga.g, pixel_vga.g};
   assign b = {pixel_vga.b, pixel_vga.b};

endmodule

// ==== source/vga_scandoubler.sv ====
`timescale 1ns/1ps

`include "video_macros.svh"

module vga_scandoubler (
   input  logic                sysclk,
   input  logic                rst_n,
   input  logic                clk14en,
   input  logic                enable_scandoubling,
   input  logic                disable_scaneffect,
   input  video_pkg::pixel_t   pixel,
   input  timing_pkg::hcount_t hcount,
   input  timing_pkg::vcount_t vcount,
   input  logic                hsync_ext_n,
   input  logic                vsync_ext_n,
   input  logic                csync_ext_n,
   output video_pkg::pixel_t   pixel_out,
   output logic                hsync,
   output logic                vsync
);

   // first pixel of an input line
   logic                line_start;

   // double rate read side
   timing_pkg::hcount_t rcount;
   logic                second_half;
   logic                rd_bank;
   video_pkg::pixel_t   rd_data;

   // input vsync, per input line
   logic                vs_cur;
   logic                vs_dly;

   // stage 1, lined up with rd_data
   logic                hs_s1;
   logic                vs_s1;
   logic                half_s1;

   // halve each channel for the darkened line
   function automatic video_pkg::pixel_t dim_pixel(input video_pkg::pixel_t p);
      video_pkg::pixel_t d;
      d.r = p.r >> 1;
      d.g = p.g >> 1;
      d.b = p.b >> 1;
      return d;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // line memory
   ////////////////////////////////////////////////////////////////////////////

   // write into the bank of the current line
   // read from the bank of the previous one
   line_buffer line_buffer_i (
      .sysclk  (sysclk),
      .wr_en   (clk14en),
      .wr_bank (vcount[0]),
      .wr_addr (hcount),
      .wr_data (pixel),
      .rd_bank (rd_bank),
      .rd_addr (rcount),
      .rd_data (rd_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // read counter and line pair tracking
   ////////////////////////////////////////////////////////////////////////////

   // hcount 0 with its enable, inside the source hsync pulse
   assign line_start = clk14en && (hcount == '0) &&
                       (hsync_ext_n == timing_pkg::SYNC_ACTIVE);

   // 0..895 twice per input line
   // resync keeps the pair locked to the source
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         rcount      <= '0;
         second_half <= 1'b0;
         rd_bank     <= 1'b0;
         vs_cur      <= ~timing_pkg::SYNC_ACTIVE;
         vs_dly      <= ~timing_pkg::SYNC_ACTIVE;
      end else if (line_start) begin
         rcount      <= '0;
         second_half <= 1'b0;
         // line k-1 lives in the other bank
         rd_bank     <= ~vcount[0];
         // vsync of line k-1 goes out with line k-1
         vs_cur      <= vsync_ext_n;
         vs_dly      <= vs_cur;
      end else if (rcount == `H_TOTAL - 1) begin
         rcount      <= '0;
         second_half <= ~second_half;
      end else begin
         rcount      <= rcount + 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sync pipeline and output select
   ////////////////////////////////////////////////////////////////////////////

   // hsync decoded at the read address
   // then delayed with the pixel
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         hs_s1   <= ~timing_pkg::SYNC_ACTIVE;
         vs_s1   <= ~timing_pkg::SYNC_ACTIVE;
         half_s1 <= 1'b0;
      end else begin
         hs_s1   <= (rcount < `VGA_HSYNC_LEN) ? timing_pkg::SYNC_ACTIVE :
                                                ~timing_pkg::SYNC_ACTIVE;
         vs_s1   <= vs_dly;
         half_s1 <= second_half;
      end
   end

   // doubled path lands two cycles after rcount
   // bypass is the 15 kHz pixel, one register late
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         pixel_out <= '0;
         hsync     <= ~timing_pkg::SYNC_ACTIVE;
         vsync     <= ~timing_pkg::SYNC_ACTIVE;
      end else if (enable_scandoubling) begin
         // second line of the pair gets darker
         if (half_s1 && !disable_scaneffect) begin
            pixel_out <= dim_pixel(rd_data);
         end else begin
            pixel_out <= rd_data;
         end
         hsync <= hs_s1;
         vsync <= vs_s1;
      end else begin
         pixel_out <= pixel;
         // composite sync on the hsync pin, vsync parked
         hsync     <= csync_ext_n;
         vsync     <= ~timing_pkg::SYNC_ACTIVE;
      end
   end

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
   input  logic                sysclk,
   input  logic                wr_en,
   input  logic                wr_bank,
   input  timing_pkg::hcount_t wr_addr,
   input  video_pkg::pixel_t   wr_data,
   input  logic                rd_bank,
   input  timing_pkg::hcount_t rd_addr,
   output video_pkg::pixel_t   rd_data
);

   // bank bit on top of the pixel index
   localparam int ADDR_W = $bits(timing_pkg::hcount_t) + 1;
   localparam int DEPTH  = 2 ** ADDR_W;

   // two lines, one being written, one being read
   video_pkg::pixel_t mem [DEPTH];

   logic [ADDR_W-1:0] wr_index;
   logic [ADDR_W-1:0] rd_index;

   assign wr_index = {wr_bank, wr_addr};
   assign rd_index = {rd_bank, rd_addr};

   ////////////////////////////////////////////////////////////////////////////
   // simple dual port RAM
   ////////////////////////////////////////////////////////////////////////////

   // write side at pixel rate
   // one write per clk14en
   always_ff @(posedge sysclk) begin
      if (wr_en) begin
         mem[wr_index] <= wr_data;
      end
   end

   // read side every sysclk
   // data one cycle after the address
   always_ff @(posedge sysclk) begin
      rd_data <= mem[rd_index];
   end

   // banks never overlap in normal use
   // the reader always sits on the other line

endmodule

// ==== source/pal_video_gen.sv ====
`timescale 1ns/1ps

`include "video_macros.svh"

module pal_video_gen (
   input  logic                sysclk,
   input  logic                rst_n,
   output logic                clk14en,
   output video_pkg::pixel_t   pixel,
   output timing_pkg::hcount_t hcount,
   output timing_pkg::vcount_t vcount,
   output logic                hsync_n,
   output logic                vsync_n,
   output logic                csync_n
);

   // raster position, steps once per pixel
   timing_pkg::hcount_t hc;
   timing_pkg::vcount_t vc;

   // decoded from hc and vc, registered below
   logic              hs_n;
   logic              vs_n;
   logic              active;
   video_pkg::pixel_t pattern;

   ////////////////////////////////////////////////////////////////////////////
   // pixel enable and raster counters
   ////////////////////////////////////////////////////////////////////////////

   // 28 MHz / 2, high every second cycle
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         clk14en <= 1'b0;
      end else begin
         clk14en <= ~clk14en;
      end
   end

   // hc wraps after 896 pixels, vc after 312 lines
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         hc <= '0;
         vc <= '0;
      end else if (clk14en) begin
         if (hc == `H_TOTAL - 1) begin
            hc <= '0;
            if (vc == `V_TOTAL - 1) begin
               vc <= '0;
            end else begin
               vc <= vc + 1'b1;
            end
         end else begin
            hc <= hc + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // sync, blanking and test pattern
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      // both syncs sit at the start of their period
      hs_n   = (hc < `H_SYNC_LEN) ? timing_pkg::SYNC_ACTIVE : ~timing_pkg::SYNC_ACTIVE;
      vs_n   = (vc < `V_SYNC_LEN) ? timing_pkg::SYNC_ACTIVE : ~timing_pkg::SYNC_ACTIVE;
      active = (hc < `H_ACTIVE) && (vc < `V_ACTIVE);
      // bars of 8 pixels in red, of 64 pixels in blue
      // green steps with every line
      pattern.r = hc[5:3];
      pattern.g = vc[2:0];
      pattern.b = hc[8:6];
   end

   // outputs trail the counters by one sysclk
   // hcount and pixel change together, in a cycle with clk14en high
   always_ff @(posedge sysclk or negedge rst_n) begin
      if (!rst_n) begin
         pixel   <= '0;
         hcount  <= '0;
         vcount  <= '0;
         hsync_n <= ~timing_pkg::SYNC_ACTIVE;
         vsync_n <= ~timing_pkg::SYNC_ACTIVE;
         csync_n <= ~timing_pkg::SYNC_ACTIVE;
      end else begin
         pixel   <= active ? pattern : '0;
         hcount  <= hc;
         vcount  <= vc;
         hsync_n <= hs_n;
         vsync_n <= vs_n;
         // low while either sync is low
         csync_n <= hs_n & vs_n;
      end
   end

endmodule

// ==== source/timing_pkg.sv ====
package timing_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // raster position and sync level
   ////////////////////////////////////////////////////////////////////////////

   // pixel index inside a line
   // 10 bits cover the 896 pixels of a PAL line
   // also used as line buffer address
   typedef logic [9:0] hcount_t;

   // line index inside a frame
   // 9 bits cover the 312 lines
   // bit 0 picks the line buffer bank
   typedef logic [8:0] vcount_t;

   // level of every sync line while the pulse is on
   // hsync, vsync and csync are all low active, in and out
   localparam logic SYNC_ACTIVE = 1'b0;

endpackage

// ==== source/video_pkg.sv ====
package video_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // colour data as it leaves the video source
   ////////////////////////////////////////////////////////////////////////////

   // one channel, 8 levels
   // the board DAC takes 6 bits, the top repeats these 3
   typedef logic [2:0] color_t;

   // one pixel, 9 bits in all
   // r sits in the top bits, b in the bottom bits
   // same layout in the line buffer and at the VGA output
   typedef struct packed {
      color_t r;
      color_t g;
      color_t b;
   } pixel_t;

   // black is all zero
   // blanking and reset both use that value

endpackage

// ==== source/video_macros.svh ====
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// PAL raster, counted in 14 MHz pixels and in lines
////////////////////////////////////////////////////////////////////////////

// pixels per input line, 1792 sysclk at 28 MHz
`define H_TOTAL 896

// lines per frame
`define V_TOTAL 312

// input hsync width in pixels, starts at hcount 0
`define H_SYNC_LEN 64

// vsync length in whole lines, starts at vcount 0
`define V_SYNC_LEN 3

// visible area, counted from the top left of the raster
`define H_ACTIVE 512
`define V_ACTIVE 256

////////////////////////////////////////////////////////////////////////////
// VGA side, counted in sysclk cycles
////////////////////////////////////////////////////////////////////////////

// output hsync width, 64 of 896 cycles per doubled line
`define VGA_HSYNC_LEN 64

`endif
